/* Makefile */
TOP := tb_exu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

obj_dir/V$(TOP): src.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

/* exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
    input  exu_pkg::exu_op_e         op,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic                     use_imm,
    input  logic [exu_pkg::xlen-1:0] pc,
    output logic [exu_pkg::xlen-1:0] result,
    output logic [exu_pkg::xlen-1:0] dnpc
);
    import exu_pkg::*;

    logic [xlen-1:0] opb;
    logic [xlen-1:0] snpc;
    logic [xlen-1:0] jalr_sum;
    logic [31:0]     word_res;
    logic            taken;

    assign opb      = use_imm ? imm : src2;
    assign snpc     = pc + 64'd4;
    assign jalr_sum = src1 + imm;
    assign word_res = (op == op_subw) ? src1[31:0] - opb[31:0] : src1[31:0] + opb[31:0];

    always_comb begin
        case (op)
            op_add:   result = src1 + opb;
            op_sub:   result = src1 - opb;
            op_and:   result = src1 & opb;
            op_or:    result = src1 | opb;
            op_xor:   result = src1 ^ opb;
            op_sll:   result = src1 << opb[5:0];
            op_srl:   result = src1 >> opb[5:0];
            op_sra:   result = $signed(src1) >>> opb[5:0];
            op_slt:   result = {63'd0, $signed(src1) < $signed(opb)};
            op_sltu:  result = {63'd0, src1 < opb};
            op_addw,
            op_subw:  result = {{32{word_res[31]}}, word_res};
            op_lui:   result = imm;
            op_auipc: result = pc + imm;
            op_jal,
            op_jalr:  result = snpc;
            // effective address for loads and stores
            default:  result = src1 + imm;
        endcase
    end

    // branches always compare two registers
    always_comb begin
        case (op)
            op_beq:  taken = src1 == src2;
            op_bne:  taken = src1 != src2;
            op_blt:  taken = $signed(src1) < $signed(src2);
            op_bge:  taken = $signed(src1) >= $signed(src2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (op == op_jal || taken) begin
            dnpc = pc + imm;
        end else if (op == op_jalr) begin
            dnpc = {jalr_sum[xlen-1:1], 1'b0};
        end else begin
            dnpc = snpc;
        end
    end

endmodule

/* exu_ctrl.sv */
`timescale 1ns/1ps

module exu_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  exu_pkg::exu_op_e   op,
    input  logic               div_done,
    input  logic               mem_req_ready,
    input  logic               mem_rsp_valid,
    input  logic [4:0]         rd,
    output logic               issue_ready,
    output logic               latch,
    output logic               div_start,
    output logic               mem_req_valid,
    output logic               mem_we,
    output logic               reg_wen,
    output exu_pkg::res_src_e  res_sel,
    output logic               retire_valid
);
    import exu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_exec,
        st_div_wait,
        st_mem_req,
        st_mem_rsp,
        st_retire
    } state_e;

    state_e   state;
    state_e   state_nxt;
    res_src_e issued_src;
    logic     awake;

    // one idle cycle after reset before taking work
    assign issue_ready = awake && state == st_idle;
    assign latch       = issue_valid && issue_ready;
    assign issued_src  = res_src_of(op);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (latch) begin
                    if (issued_src == res_div) begin
                        state_nxt = st_exec;
                    end else if (issued_src == res_load || is_store(op)) begin
                        state_nxt = st_mem_req;
                    end else begin
                        state_nxt = st_retire;
                    end
                end
            end
            st_exec:     state_nxt = st_div_wait;
            st_div_wait: state_nxt = div_done ? st_retire : st_div_wait;
            st_mem_req:  state_nxt = mem_req_ready ? st_mem_rsp : st_mem_req;
            st_mem_rsp:  state_nxt = mem_rsp_valid ? st_retire : st_mem_rsp;
            default:     state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            awake   <= 1'b0;
            res_sel <= res_none;
            mem_we  <= 1'b0;
        end else begin
            state <= state_nxt;
            awake <= 1'b1;
            if (latch) begin
                res_sel <= issued_src;
                mem_we  <= is_store(op);
            end
        end
    end

    assign div_start     = state == st_exec;
    assign mem_req_valid = state == st_mem_req;
    assign retire_valid  = state == st_retire;
    assign reg_wen       = retire_valid && res_sel != res_none;

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid)
        else $error("memory request withdrawn before acceptance");

    // instruction register must not move under an instruction in flight
    rd_held: assert property (@(posedge clk) disable iff (!rst_n)
        state != st_idle |=> $stable(rd))
        else $error("destination register changed before retire");

endmodule

/* exu_divider.sv */
`timescale 1ns/1ps

module exu_divider (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [exu_pkg::xlen-1:0] dividend,
    input  logic [exu_pkg::xlen-1:0] divisor,
    output logic                     busy,
    output logic                     done,
    output logic [exu_pkg::xlen-1:0] quotient,
    output logic [exu_pkg::xlen-1:0] remainder
);
    import exu_pkg::*;

    logic [6:0]      cnt;
    logic [xlen-1:0] dvs_q;
    logic [xlen-1:0] rem_in;
    logic [xlen-1:0] quo_in;
    logic [xlen-1:0] dvs_in;
    logic [xlen:0]   shifted;
    logic            fits;

    // first step already runs on the start edge
    assign rem_in = start ? '0 : remainder;
    assign quo_in = start ? dividend : quotient;
    assign dvs_in = start ? divisor : dvs_q;

    // zero divisor always fits: all-ones quotient, dividend left as remainder
    assign shifted = {rem_in, quo_in[xlen-1]};
    assign fits    = shifted >= {1'b0, dvs_in};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= 7'd1;
        end else if (busy) begin
            cnt <= cnt + 7'd1;
            if (cnt == 7'(xlen - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            dvs_q     <= dvs_in;
            remainder <= fits ? shifted[xlen-1:0] - dvs_in : shifted[xlen-1:0];
            quotient  <= {quo_in[xlen-2:0], fits};
        end
    end

    // high during the cycle of the last step
    assign done = busy && cnt == 7'(xlen - 1);

    start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("divider restarted while busy");

endmodule

/* exu_lsu.sv */
`timescale 1ns/1ps

module exu_lsu (
    input  exu_pkg::exu_op_e           op,
    input  logic [exu_pkg::xlen-1:0]   addr,
    input  logic [exu_pkg::xlen-1:0]   store_data,
    input  logic [exu_pkg::xlen-1:0]   mem_rdata,
    output logic [exu_pkg::xlen-1:0]   mem_wdata,
    output logic [lsu_pkg::mask_w-1:0] mem_wmask,
    output logic [exu_pkg::xlen-1:0]   load_result
);
    import exu_pkg::*;
    import lsu_pkg::*;

    mem_size_e         size;
    logic [2:0]        offset;
    logic [5:0]        bit_shift;
    logic [mask_w-1:0] size_mask;
    logic [xlen-1:0]   lane;
    logic              sign;
    logic              aligned;

    assign size      = size_of(op);
    assign offset    = addr[2:0];
    assign bit_shift = {offset, 3'b000};
    assign sign      = load_signed(op);

    always_comb begin
        case (size)
            size_b: begin
                size_mask = 8'h01;
                aligned   = 1'b1;
            end
            size_h: begin
                size_mask = 8'h03;
                aligned   = offset[0] == 1'b0;
            end
            size_w: begin
                size_mask = 8'h0f;
                aligned   = offset[1:0] == 2'b00;
            end
            default: begin
                size_mask = 8'hff;
                aligned   = offset == 3'b000;
            end
        endcase
    end

    // bytes outside the mask are don't care
    assign mem_wmask = size_mask << offset;
    assign mem_wdata = store_data << bit_shift;

    assign lane = mem_rdata >> bit_shift;

    always_comb begin
        case (size)
            size_b:  load_result = {{56{sign & lane[7]}}, lane[7:0]};
            size_h:  load_result = {{48{sign & lane[15]}}, lane[15:0]};
            size_w:  load_result = {{32{sign & lane[31]}}, lane[31:0]};
            default: load_result = lane;
        endcase
    end

    always_comb begin
        if (res_src_of(op) == res_load || is_store(op)) begin
            assert final (aligned)
                else $error("misaligned memory access at %h", addr);
        end
    end

endmodule

/* exu_pkg.sv */
package exu_pkg;

    localparam int xlen = 64;

    typedef enum logic [5:0] {
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addw, op_subw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge,
        op_divu, op_remu,
        op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu,
        op_sd, op_sw, op_sh, op_sb
    } exu_op_e;

    typedef enum logic [1:0] {
        res_alu,
        res_div,
        res_load,
        res_none
    } res_src_e;

    function automatic logic is_branch(exu_op_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge};
    endfunction

    function automatic logic is_store(exu_op_e op);
        return op inside {op_sd, op_sw, op_sh, op_sb};
    endfunction

    // branches and stores have no destination
    function automatic res_src_e res_src_of(exu_op_e op);
        if (op inside {op_divu, op_remu}) begin
            return res_div;
        end
        if (op inside {op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu}) begin
            return res_load;
        end
        if (is_branch(op) || is_store(op)) begin
            return res_none;
        end
        return res_alu;
    endfunction

endpackage

/* exu_regfile.sv */
`timescale 1ns/1ps

module exu_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [4:0]               ra1,
    input  logic [4:0]               ra2,
    input  logic                     wen,
    input  logic [4:0]               wa,
    input  logic [exu_pkg::xlen-1:0] wd,
    input  logic [4:0]               dbg_addr,
    output logic [exu_pkg::xlen-1:0] rd1,
    output logic [exu_pkg::xlen-1:0] rd2,
    output logic [exu_pkg::xlen-1:0] dbg_data
);
    import exu_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1      = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2      = (ra2 == 5'd0) ? '0 : regs[ra2];
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

/* exu_top.sv */
`timescale 1ns/1ps

module exu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_valid,
    output logic                       issue_ready,
    input  exu_pkg::exu_op_e           op,
    input  logic [4:0]                 rd,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic [exu_pkg::xlen-1:0]   imm,
    input  logic                       use_imm,
    input  logic [exu_pkg::xlen-1:0]   pc,
    output logic                       retire_valid,
    output logic [exu_pkg::xlen-1:0]   dnpc,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output logic                       mem_we,
    output logic [exu_pkg::xlen-1:0]   mem_addr,
    output logic [exu_pkg::xlen-1:0]   mem_wdata,
    output logic [lsu_pkg::mask_w-1:0] mem_wmask,
    input  logic                       mem_rsp_valid,
    input  logic [exu_pkg::xlen-1:0]   mem_rdata,
    input  logic [4:0]                 dbg_addr,
    output logic [exu_pkg::xlen-1:0]   dbg_data
);
    import exu_pkg::*;

    exu_op_e         ir_op;
    logic [4:0]      ir_rd;
    logic [4:0]      ir_rs1;
    logic [4:0]      ir_rs2;
    logic [xlen-1:0] ir_imm;
    logic [xlen-1:0] ir_pc;
    logic            ir_use_imm;
    logic            latch;
    logic            div_start;
    logic            div_busy;
    logic            div_done;
    logic            reg_wen;
    res_src_e        res_sel;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] quotient;
    logic [xlen-1:0] remainder;
    logic [xlen-1:0] load_result;
    logic [xlen-1:0] rdata_q;
    logic [xlen-1:0] wb_data;

    // falls back to an add once retired, so the lsu sees no access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_op <= op_add;
        end else if (latch) begin
            ir_op <= op;
        end else if (retire_valid) begin
            ir_op <= op_add;
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            ir_rd      <= rd;
            ir_rs1     <= rs1;
            ir_rs2     <= rs2;
            ir_imm     <= imm;
            ir_pc      <= pc;
            ir_use_imm <= use_imm;
        end
    end

    // response data only lasts for the strobe
    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            rdata_q <= mem_rdata;
        end
    end

    always_comb begin
        case (res_sel)
            res_div:  wb_data = (ir_op == op_remu) ? remainder : quotient;
            res_load: wb_data = load_result;
            default:  wb_data = alu_result;
        endcase
    end

    assign mem_addr = {alu_result[xlen-1:3], 3'b000};

    exu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .ra1(ir_rs1), .ra2(ir_rs2),
        .wen(reg_wen), .wa(ir_rd), .wd(wb_data),
        .dbg_addr(dbg_addr),
        .rd1(src1), .rd2(src2), .dbg_data(dbg_data)
    );

    exu_alu u_alu (
        .op(ir_op), .src1(src1), .src2(src2),
        .imm(ir_imm), .use_imm(ir_use_imm), .pc(ir_pc),
        .result(alu_result), .dnpc(dnpc)
    );

    exu_divider u_divider (
        .clk(clk), .rst_n(rst_n), .start(div_start),
        .dividend(src1), .divisor(src2),
        .busy(div_busy), .done(div_done),
        .quotient(quotient), .remainder(remainder)
    );

    exu_lsu u_lsu (
        .op(ir_op), .addr(alu_result), .store_data(src2), .mem_rdata(rdata_q),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .load_result(load_result)
    );

    exu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .op(op), .div_done(div_done),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid), .rd(ir_rd),
        .issue_ready(issue_ready), .latch(latch), .div_start(div_start),
        .mem_req_valid(mem_req_valid), .mem_we(mem_we), .reg_wen(reg_wen),
        .res_sel(res_sel), .retire_valid(retire_valid)
    );

    no_issue_in_div: assert property (@(posedge clk) disable iff (!rst_n)
        div_busy |-> !issue_ready)
        else $error("issue port open while the divider runs");

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    localparam int mask_w = 8;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w,
        size_d
    } mem_size_e;

    function automatic mem_size_e size_of(exu_pkg::exu_op_e op);
        case (op)
            exu_pkg::op_lb, exu_pkg::op_lbu, exu_pkg::op_sb: return size_b;
            exu_pkg::op_lh, exu_pkg::op_lhu, exu_pkg::op_sh: return size_h;
            exu_pkg::op_lw, exu_pkg::op_lwu, exu_pkg::op_sw: return size_w;
            default: return size_d;
        endcase
    endfunction

    function automatic logic load_signed(exu_pkg::exu_op_e op);
        return op inside {exu_pkg::op_lb, exu_pkg::op_lh, exu_pkg::op_lw, exu_pkg::op_ld};
    endfunction

endpackage

/* src.f */
exu_pkg.sv
lsu_pkg.sv
exu_regfile.sv
exu_alu.sv
exu_divider.sv
exu_lsu.sv
exu_ctrl.sv
exu_top.sv
tb_exu.sv

/* tb_exu.sv */
`timescale 1ns/1ps

module tb_exu;
    import exu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    logic        issue_ready;
    exu_op_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [63:0] imm;
    logic        use_imm;
    logic [63:0] pc;
    logic        retire_valid;
    logic [63:0] dnpc;
    logic        mem_req_valid;
    logic        mem_req_ready = 1'b0;
    logic        mem_we;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_wmask;
    logic        mem_rsp_valid = 1'b0;
    logic [63:0] mem_rdata = '0;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;

    integer      seed = 32'hb1e4_ce3d;
    int          checks = 0;
    int          errors = 0;
    logic [63:0] model [0:31];
    logic [63:0] mem [0:63];
    logic [63:0] exp_mem [0:63];
    logic [63:0] pc_now = 64'h0000_0000_8000_1000;
    logic [63:0] issued_pc;
    logic [63:0] got_dnpc;
    int          retire_lat;
    logic        rsp_pending = 1'b0;
    int          rsp_delay = 0;
    logic [63:0] rsp_data = '0;
    logic [5:0]  widx;

    exu_top uut (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .op(op), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .use_imm(use_imm), .pc(pc),
        .retire_valid(retire_valid), .dnpc(dnpc),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] fill_word(input int i);
        return {32'(i) * 32'h9e37_79b9, 32'(i << 3) ^ 32'hc0de_5a11};
    endfunction

    // data memory, random back-pressure and response delay
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
            rsp_pending = 1'b0;
            for (int i = 0; i < 64; i++) begin
                mem[i] = fill_word(i);
            end
        end else begin
            mem_rsp_valid = 1'b0;
            if (rsp_pending) begin
                if (rsp_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rdata = rsp_data;
                    rsp_pending = 1'b0;
                end else begin
                    rsp_delay = rsp_delay - 1;
                end
            end
            mem_req_ready = ($random(seed) & 3) != 0;
            // request transfers on the coming rising edge
            if (mem_req_valid && mem_req_ready) begin
                widx = mem_addr[8:3];
                rsp_data = mem[widx];
                if (mem_we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (mem_wmask[b]) begin
                            mem[widx][b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                    end
                end
                rsp_delay = $random(seed) & 3;
                rsp_pending = 1'b1;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("timeout: %s at %0t", why, $time);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
            end
    endtask

    task automatic check_reg(input logic [4:0] r, input string what);
        dbg_addr = r;
        @(negedge clk);
        check_val($sformatf("%s x%0d", what, r), dbg_data, model[r]);
    endtask

    // returns on the falling edge inside the retire pulse
    task automatic run_instr(input exu_op_e o, input logic [4:0] d, input logic [4:0] s1,
                             input logic [4:0] s2, input logic [63:0] im, input logic ui);
        int wait_cnt;
        wait_cnt = 0;
        while (!issue_ready) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 20) begin
                abort_run("issue_ready stayed low");
            end
        end
        op = o;
        rd = d;
        rs1 = s1;
        rs2 = s2;
        imm = im;
        use_imm = ui;
        pc = pc_now;
        issue_valid = 1'b1;
        issued_pc = pc_now;
        pc_now = pc_now + 64'd4;
        retire_lat = 0;
        do begin
            @(negedge clk);
            issue_valid = 1'b0;
            retire_lat++;
            if (retire_lat > 200) begin
                abort_run("instruction never retired");
            end
        end while (!retire_valid);
        got_dnpc = dnpc;
    endtask

    task automatic set_reg(input logic [4:0] r, input logic [63:0] v);
        run_instr(op_lui, r, 5'd0, 5'd0, v, 1'b1);
        if (r != 5'd0) begin
            model[r] = v;
        end
    endtask

    // lui and auipc take the immediate whatever the operand select
    function automatic logic [63:0] alu_ref(input exu_op_e o, input logic [63:0] a,
                                            input logic [63:0] b, input logic [63:0] im,
                                            input logic [63:0] pcv);
        logic [31:0] w;
        case (o)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[5:0];
            op_srl:  return a >> b[5:0];
            op_sra:  return $signed(a) >>> b[5:0];
            op_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu: return (a < b) ? 64'd1 : 64'd0;
            op_addw: begin
                w = a[31:0] + b[31:0];
                return {{32{w[31]}}, w};
            end
            op_subw: begin
                w = a[31:0] - b[31:0];
                return {{32{w[31]}}, w};
            end
            op_lui:  return im;
            default: return pcv + im;
        endcase
    endfunction

    task automatic store_ref(input logic [63:0] addr, input int n, input logic [63:0] data);
        for (int k = 0; k < n; k++) begin
            exp_mem[addr[8:3]][(int'(addr[2:0]) + k) * 8 +: 8] = data[k*8 +: 8];
        end
    endtask

    function automatic logic [63:0] load_ref(input logic [63:0] addr, input int n,
                                             input logic sext);
        logic [63:0] word;
        logic [63:0] val;
        word = exp_mem[addr[8:3]];
        val = '0;
        for (int k = 0; k < n; k++) begin
            val[k*8 +: 8] = word[(int'(addr[2:0]) + k) * 8 +: 8];
        end
        if (sext && val[n*8-1]) begin
            for (int k = n; k < 8; k++) begin
                val[k*8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic reset_checks();
        check_val("issue_ready right after reset", 64'(issue_ready), 64'd0);
        check_val("mem_req_valid after reset", 64'(mem_req_valid), 64'd0);
        check_val("retire_valid after reset", 64'(retire_valid), 64'd0);
        @(negedge clk);
        check_val("issue_ready one cycle later", 64'(issue_ready), 64'd1);
        for (int r = 0; r < 32; r++) begin
            check_reg(5'(r), "reset value");
        end
        run_instr(op_add, 5'd0, 5'd0, 5'd0, 64'd77, 1'b1);
        check_reg(5'd0, "add into zero register");
        set_reg(5'd0, 64'hdead_beef_0bad_f00d);
        check_reg(5'd0, "lui into zero register");
    endtask

    task automatic alu_ops();
        exu_op_e ops [0:13] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl,
                                op_sra, op_slt, op_sltu, op_addw, op_subw, op_lui, op_auipc};
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] im;
        for (int round = 0; round < 3; round++) begin
            a = {$random(seed), $random(seed)};
            b = (round == 2) ? a : {$random(seed), $random(seed)};
            set_reg(5'd1, a);
            set_reg(5'd2, b);
            for (int i = 0; i < 14; i++) begin
                for (int u = 0; u < 2; u++) begin
                    im = {$random(seed), $random(seed)};
                    run_instr(ops[i], 5'd3, 5'd1, 5'd2, im, u[0]);
                    model[3] = alu_ref(ops[i], a, u[0] ? im : b, im, issued_pc);
                    check_val($sformatf("%s latency", ops[i].name()), 64'(retire_lat), 64'd1);
                    check_val($sformatf("%s dnpc", ops[i].name()), got_dnpc, issued_pc + 64'd4);
                    check_reg(5'd3, ops[i].name());
                end
            end
        end
    endtask

    task automatic control_flow();
        exu_op_e br [0:3] = '{op_beq, op_bne, op_blt, op_bge};
        logic [63:0] va [0:2] = '{64'h10, 64'hffff_ffff_ffff_fff0, 64'h10};
        logic [63:0] vb [0:2] = '{64'h10, 64'h10, 64'hffff_ffff_ffff_fff0};
        logic [63:0] off;
        logic        taken;
        set_reg(5'd5, 64'h5555_aaaa_0000_ffff);
        // equal, signed-less and signed-greater pairs
        for (int p = 0; p < 3; p++) begin
            set_reg(5'd1, va[p]);
            set_reg(5'd2, vb[p]);
            for (int i = 0; i < 4; i++) begin
                case (br[i])
                    op_beq:  taken = va[p] == vb[p];
                    op_bne:  taken = va[p] != vb[p];
                    op_blt:  taken = $signed(va[p]) < $signed(vb[p]);
                    default: taken = $signed(va[p]) >= $signed(vb[p]);
                endcase
                off = (i % 2 == 0) ? 64'h100 : 64'hffff_ffff_ffff_ffe0;
                run_instr(br[i], 5'd5, 5'd1, 5'd2, off, 1'b0);
                check_val($sformatf("%s latency", br[i].name()), 64'(retire_lat), 64'd1);
                check_val($sformatf("%s dnpc", br[i].name()), got_dnpc,
                          taken ? issued_pc + off : issued_pc + 64'd4);
                check_reg(5'd5, "branch left rd");
            end
        end
        run_instr(op_jal, 5'd6, 5'd0, 5'd0, 64'h800, 1'b1);
        model[6] = issued_pc + 64'd4;
        check_val("jal dnpc", got_dnpc, issued_pc + 64'h800);
        check_reg(5'd6, "jal link");
        set_reg(5'd7, 64'h0000_0000_8000_2001);
        run_instr(op_jalr, 5'd8, 5'd7, 5'd0, 64'h10, 1'b1);
        model[8] = issued_pc + 64'd4;
        check_val("jalr dnpc", got_dnpc, 64'h0000_0000_8000_2010);
        check_reg(5'd8, "jalr link");
    endtask

    task automatic divides();
        logic [63:0] a;
        logic [63:0] b;
        for (int i = 0; i < 8; i++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)} >> ($random(seed) & 63);
            if (i == 5) begin
                b = '0;
            end else if (i == 6) begin
                b = a + 64'd1;
            end
            set_reg(5'd1, a);
            set_reg(5'd2, b);
            run_instr(op_divu, 5'd9, 5'd1, 5'd2, 64'd0, 1'b0);
            model[9] = (b == 0) ? '1 : a / b;
            check_val("divu dnpc", got_dnpc, issued_pc + 64'd4);
            check_reg(5'd9, "divu");
            run_instr(op_remu, 5'd11, 5'd1, 5'd2, 64'd0, 1'b0);
            model[11] = (b == 0) ? a : a % b;
            check_reg(5'd11, "remu");
        end
    endtask

    task automatic stores_and_loads();
        exu_op_e st_ops [0:3] = '{op_sd, op_sw, op_sh, op_sb};
        int      st_size [0:3] = '{8, 4, 2, 1};
        exu_op_e ld_ops [0:6] = '{op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu};
        int      ld_size [0:6] = '{8, 4, 4, 2, 2, 1, 1};
        logic    ld_sext [0:6] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        logic [63:0] base;
        logic [63:0] addr;
        logic [63:0] data;
        base = 64'h100;
        set_reg(5'd12, base);
        set_reg(5'd14, 64'h0123_4567_89ab_cdef);
        // one doubleword per store size, the fifth keeps its fill pattern
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += st_size[s]) begin
                data = {$random(seed), $random(seed)};
                set_reg(5'd13, data);
                addr = base + 64'(s * 8 + off);
                run_instr(st_ops[s], 5'd14, 5'd12, 5'd13, 64'(s * 8 + off), 1'b1);
                store_ref(addr, st_size[s], data);
                check_val($sformatf("%s memory at %h", st_ops[s].name(), addr),
                          mem[addr[8:3]], exp_mem[addr[8:3]]);
                check_reg(5'd14, "store left rd");
            end
        end
        for (int l = 0; l < 7; l++) begin
            for (int dw = 0; dw < 5; dw++) begin
                for (int off = 0; off < 8; off += ld_size[l]) begin
                    addr = base + 64'(dw * 8 + off);
                    run_instr(ld_ops[l], 5'd15, 5'd12, 5'd0, 64'(dw * 8 + off), 1'b1);
                    model[15] = load_ref(addr, ld_size[l], ld_sext[l]);
                    check_reg(5'd15, $sformatf("%s from %h into", ld_ops[l].name(), addr));
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        op = op_add;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        use_imm = 1'b0;
        pc = '0;
        dbg_addr = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            exp_mem[i] = fill_word(i);
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        reset_checks();
        alu_ops();
        control_flow();
        divides();
        stores_and_loads();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
